//--- Bender.yml
package:
  name: fetch_translate

sources:
  - include_dirs:
      - src
    files:
      - src/fetch_pkg.sv
      - src/csr_regs.sv
      - src/tlb.sv
      - src/fetch_stage.sv
      - src/fetch_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/tb_clock.sv
      - tests/fetch_properties.sv
      - tests/fetch_tb.sv

//--- src/csr_regs.sv
`include "fetch_macros.svh"

module csr_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic                   pready,
    output logic [31:0]            prdata,
    output fetch_pkg::csr_word_u   crmd,
    output fetch_pkg::csr_word_u   dmw0,
    output fetch_pkg::csr_word_u   dmw1,
    output logic [9:0]             asid,
    output logic                   tlb_we,
    output logic [`TLB_IDX_W-1:0]  tlb_windex,
    output fetch_pkg::tlb_entry_t  tlb_wentry
);
    import fetch_pkg::*;

    // ne bit plus index
    localparam logic [31:0] TLBIDX_MASK =
        {1'b1, {(31 - `TLB_IDX_W){1'b0}}, {`TLB_IDX_W{1'b1}}};
    localparam logic [31:0] TLBEHI_MASK = 32'hffff_e000;
    // ppn, g, plv, v
    localparam logic [31:0] ELO_MASK    = 32'h0fff_ff4d;

    logic        apb_wr;
    csr_word_u   wview;
    csr_word_u   crmd_wr;
    csr_word_u   dmw_wr;
    logic [31:0] tlbidx_q;
    logic [31:0] tlbehi_q;
    logic [31:0] elo0_q;
    logic [31:0] elo1_q;

    function automatic tlb_page_t elo_page(logic [31:0] elo);
        return '{ppn: elo[27:8], plv: elo[3:2], v: elo[0]};
    endfunction

    // no wait states
    assign pready = psel && penable;
    assign apb_wr = psel && penable && pwrite;

    assign wview = pwdata;

    // keep only the implemented fields of each view
    always_comb begin
        crmd_wr          = '0;
        crmd_wr.crmd.plv = wview.crmd.plv;
        crmd_wr.crmd.da  = wview.crmd.da;
        dmw_wr           = '0;
        dmw_wr.dmw.vseg  = wview.dmw.vseg;
        dmw_wr.dmw.pseg  = wview.dmw.pseg;
        dmw_wr.dmw.plv3  = wview.dmw.plv3;
        dmw_wr.dmw.plv0  = wview.dmw.plv0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // direct mode, plv0
            crmd     <= 32'h0000_0008;
            dmw0     <= '0;
            dmw1     <= '0;
            asid     <= '0;
            tlbidx_q <= '0;
            tlbehi_q <= '0;
            elo0_q   <= '0;
            elo1_q   <= '0;
        end else if (apb_wr) begin
            case (paddr)
                `CSR_CRMD:    crmd     <= crmd_wr;
                `CSR_ASID:    asid     <= pwdata[9:0];
                `CSR_DMW0:    dmw0     <= dmw_wr;
                `CSR_DMW1:    dmw1     <= dmw_wr;
                `CSR_TLBIDX:  tlbidx_q <= pwdata & TLBIDX_MASK;
                `CSR_TLBEHI:  tlbehi_q <= pwdata & TLBEHI_MASK;
                `CSR_TLBELO0: elo0_q   <= pwdata & ELO_MASK;
                `CSR_TLBELO1: elo1_q   <= pwdata & ELO_MASK;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (paddr)
            `CSR_CRMD:    prdata = crmd;
            `CSR_ASID:    prdata = {22'd0, asid};
            `CSR_DMW0:    prdata = dmw0;
            `CSR_DMW1:    prdata = dmw1;
            `CSR_TLBIDX:  prdata = tlbidx_q;
            `CSR_TLBEHI:  prdata = tlbehi_q;
            `CSR_TLBELO0: prdata = elo0_q;
            `CSR_TLBELO1: prdata = elo1_q;
            default:      prdata = 32'd0;
        endcase
    end

    // command write fires the tlb fill from the staging registers
    assign tlb_we     = apb_wr && (paddr == `CSR_TLBCMD);
    assign tlb_windex = tlbidx_q[`TLB_IDX_W-1:0];
    assign tlb_wentry = '{
        e:    ~tlbidx_q[31],
        vppn: tlbehi_q[31:13],
        asid: asid,
        g:    elo0_q[6] & elo1_q[6],
        page: {elo_page(elo1_q), elo_page(elo0_q)}
    };

endmodule

//--- src/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// tlb geometry
`define TLB_NUM     4
`define TLB_IDX_W   2

`define RESET_PC    32'h1c000000

// apb word addresses of the csr registers
`define CSR_CRMD    8'h00
`define CSR_ASID    8'h01
`define CSR_DMW0    8'h02
`define CSR_DMW1    8'h03
`define CSR_TLBIDX  8'h04
`define CSR_TLBEHI  8'h05
`define CSR_TLBELO0 8'h06
`define CSR_TLBELO1 8'h07
`define CSR_TLBCMD  8'h08

`endif

//--- src/fetch_pkg.sv
package fetch_pkg;

    // crmd layout, da at bit 3, plv at bits 1:0
    typedef struct packed {
        logic [27:0] rsv1;
        logic        da;
        logic        rsv0;
        logic [1:0]  plv;
    } crmd_t;

    // dmw layout
    typedef struct packed {
        logic [2:0]  vseg;
        logic        rsv2;
        logic [2:0]  pseg;
        logic [20:0] rsv1;
        logic        plv3;
        logic [1:0]  rsv0;
        logic        plv0;
    } dmw_t;

    typedef union packed {
        crmd_t crmd;
        dmw_t  dmw;
    } csr_word_u;

    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic        v;
    } tlb_page_t;

    // page[0] even, page[1] odd
    typedef struct packed {
        logic                  e;
        logic [18:0]           vppn;
        logic [9:0]            asid;
        logic                  g;
        tlb_page_t [1:0]       page;
    } tlb_entry_t;

    typedef struct packed {
        logic        found;
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic        v;
    } xlate_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        ex;
        logic [5:0]  ecode;
    } fetch_out_t;

    localparam logic [5:0] ECODE_TLBR = 6'h3f;
    localparam logic [5:0] ECODE_PIF  = 6'h03;
    localparam logic [5:0] ECODE_PPI  = 6'h07;

endpackage

//--- src/fetch_stage.sv
`include "fetch_macros.svh"

module fetch_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  fetch_pkg::csr_word_u   crmd,
    input  fetch_pkg::csr_word_u   dmw0,
    input  fetch_pkg::csr_word_u   dmw1,
    output logic [18:0]            s_vppn,
    output logic                   s_odd,
    input  fetch_pkg::xlate_t      s_res,
    output logic                   inst_sram_req,
    output logic [31:0]            inst_sram_addr,
    input  logic                   inst_sram_addr_ok,
    input  logic                   inst_sram_data_ok,
    input  logic [31:0]            inst_sram_rdata,
    output logic                   fs_valid,
    output fetch_pkg::fetch_out_t  fs_out,
    input  logic                   fs_allowin,
    input  logic                   redirect,
    input  logic [31:0]            redirect_pc
);
    import fetch_pkg::*;

    logic [31:0] pc_q;
    logic [31:0] req_pc_q;
    logic        wait_q;
    logic        discard_q;
    logic        halt_q;
    logic [1:0]  plv;
    logic [31:0] pa;
    logic        fault;
    logic [5:0]  fault_code;
    logic        slot_free;
    logic        can_fetch;
    logic        accept;
    logic        resp;
    logic        take_resp;
    logic        take_fault;

    function automatic logic dmw_hit(csr_word_u w, logic [1:0] cur_plv, logic [2:0] seg);
        return (w.dmw.vseg == seg)
            && ((cur_plv == 2'd0 && w.dmw.plv0) || (cur_plv == 2'd3 && w.dmw.plv3));
    endfunction

    assign plv    = crmd.crmd.plv;
    assign s_vppn = pc_q[31:13];
    assign s_odd  = pc_q[12];

    // direct, then windows, then tlb
    always_comb begin
        pa         = pc_q;
        fault      = 1'b0;
        fault_code = '0;
        if (crmd.crmd.da) begin
            pa = pc_q;
        end else if (dmw_hit(dmw0, plv, pc_q[31:29])) begin
            pa = {dmw0.dmw.pseg, pc_q[28:0]};
        end else if (dmw_hit(dmw1, plv, pc_q[31:29])) begin
            pa = {dmw1.dmw.pseg, pc_q[28:0]};
        end else if (!s_res.found) begin
            fault      = 1'b1;
            fault_code = ECODE_TLBR;
        end else if (!s_res.v) begin
            fault      = 1'b1;
            fault_code = ECODE_PIF;
        end else if (plv > s_res.plv) begin
            fault      = 1'b1;
            fault_code = ECODE_PPI;
        end else begin
            pa = {s_res.ppn, pc_q[11:0]};
        end
    end

    // slot empty or draining, nothing in memory
    assign slot_free  = !fs_valid || fs_allowin;
    assign can_fetch  = !reset && slot_free && !wait_q && !halt_q && !redirect;
    assign take_fault = can_fetch && fault;

    assign inst_sram_req  = can_fetch && !fault;
    assign inst_sram_addr = pa;

    assign accept    = inst_sram_req && inst_sram_addr_ok;
    assign resp      = wait_q && inst_sram_data_ok;
    assign take_resp = resp && !discard_q && !redirect;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q      <= `RESET_PC;
            wait_q    <= 1'b0;
            discard_q <= 1'b0;
            halt_q    <= 1'b0;
        end else begin
            if (redirect) begin
                pc_q <= redirect_pc;
            end else if (accept) begin
                pc_q <= pc_q + 32'd4;
            end
            if (accept) begin
                wait_q <= 1'b1;
            end else if (resp) begin
                wait_q <= 1'b0;
            end
            // response still due after a redirect is stale
            if (redirect && wait_q && !inst_sram_data_ok) begin
                discard_q <= 1'b1;
            end else if (resp) begin
                discard_q <= 1'b0;
            end
            if (redirect) begin
                halt_q <= 1'b0;
            end else if (take_fault) begin
                halt_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_pc_q <= pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            fs_valid <= 1'b0;
        end else if (take_resp || take_fault) begin
            fs_valid <= 1'b1;
        end else if (fs_allowin) begin
            fs_valid <= 1'b0;
        end
    end

    // loads only into an empty slot, so held under back-pressure
    always_ff @(posedge clk) begin
        if (take_resp) begin
            fs_out <= '{pc: req_pc_q, inst: inst_sram_rdata, ex: 1'b0, ecode: 6'd0};
        end else if (take_fault) begin
            fs_out <= '{pc: pc_q, inst: 32'd0, ex: 1'b1, ecode: fault_code};
        end
    end

endmodule

//--- src/fetch_top.sv
`include "fetch_macros.svh"

module fetch_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic                   pready,
    output logic [31:0]            prdata,
    output logic                   inst_sram_req,
    output logic [31:0]            inst_sram_addr,
    input  logic                   inst_sram_addr_ok,
    input  logic                   inst_sram_data_ok,
    input  logic [31:0]            inst_sram_rdata,
    output logic                   fs_valid,
    output fetch_pkg::fetch_out_t  fs_out,
    input  logic                   fs_allowin,
    input  logic                   redirect,
    input  logic [31:0]            redirect_pc
);
    import fetch_pkg::*;

    csr_word_u              crmd;
    csr_word_u              dmw0;
    csr_word_u              dmw1;
    logic [9:0]             asid;
    logic                   tlb_we;
    logic [`TLB_IDX_W-1:0]  tlb_windex;
    tlb_entry_t             tlb_wentry;
    logic [18:0]            s_vppn;
    logic                   s_odd;
    xlate_t                 s_res;

    csr_regs u_csr (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pready     (pready),
        .prdata     (prdata),
        .crmd       (crmd),
        .dmw0       (dmw0),
        .dmw1       (dmw1),
        .asid       (asid),
        .tlb_we     (tlb_we),
        .tlb_windex (tlb_windex),
        .tlb_wentry (tlb_wentry)
    );

    tlb u_tlb (
        .clk     (clk),
        .reset   (reset),
        .s_vppn  (s_vppn),
        .s_odd   (s_odd),
        .asid    (asid),
        .s_res   (s_res),
        .we      (tlb_we),
        .w_index (tlb_windex),
        .w_entry (tlb_wentry)
    );

    fetch_stage u_fetch (
        .clk               (clk),
        .reset             (reset),
        .crmd              (crmd),
        .dmw0              (dmw0),
        .dmw1              (dmw1),
        .s_vppn            (s_vppn),
        .s_odd             (s_odd),
        .s_res             (s_res),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .fs_valid          (fs_valid),
        .fs_out            (fs_out),
        .fs_allowin        (fs_allowin),
        .redirect          (redirect),
        .redirect_pc       (redirect_pc)
    );

endmodule

//--- src/tlb.sv
`include "fetch_macros.svh"

module tlb (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [18:0]            s_vppn,
    input  logic                   s_odd,
    input  logic [9:0]             asid,
    output fetch_pkg::xlate_t      s_res,
    input  logic                   we,
    input  logic [`TLB_IDX_W-1:0]  w_index,
    input  fetch_pkg::tlb_entry_t  w_entry
);
    import fetch_pkg::*;

    tlb_entry_t          entry [`TLB_NUM];
    logic [`TLB_NUM-1:0] hit;
    tlb_entry_t          hit_entry;
    tlb_page_t           page;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TLB_NUM; i++) begin
                entry[i] <= '0;
            end
        end else if (we) begin
            entry[w_index] <= w_entry;
        end
    end

    // match on vppn, global entries ignore asid
    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            hit[i] = entry[i].e
                  && (entry[i].vppn == s_vppn)
                  && (entry[i].g || (entry[i].asid == asid));
        end
    end

    // highest matching index wins if software left duplicates
    always_comb begin
        hit_entry = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (hit[i]) begin
                hit_entry = entry[i];
            end
        end
    end

    // bit 12 picks even or odd page
    assign page = hit_entry.page[s_odd];

    assign s_res = '{
        found: |hit,
        ppn:   page.ppn,
        plv:   page.plv,
        v:     page.v
    };

endmodule

//--- tb.f
+incdir+src
src/fetch_pkg.sv
src/csr_regs.sv
src/tlb.sv
src/fetch_stage.sv
src/fetch_top.sv
tests/tb_clock.sv
tests/fetch_properties.sv
tests/fetch_tb.sv

//--- tests/fetch_properties.sv
`include "fetch_macros.svh"

module fetch_properties (
    input logic                  clk,
    input logic                  reset,
    input logic                  psel,
    input logic                  penable,
    input logic                  pwrite,
    input logic [7:0]            paddr,
    input logic                  pready,
    input logic [31:0]           prdata,
    input logic                  tlb_we,
    input logic                  inst_sram_req,
    input logic                  inst_sram_addr_ok,
    input logic                  inst_sram_data_ok,
    input logic                  fs_valid,
    input fetch_pkg::fetch_out_t fs_out,
    input logic                  fs_allowin,
    input logic                  redirect
);

    int fail_cnt = 0;

    a_no_req_in_reset: assert property (@(posedge clk) reset |-> !inst_sram_req)
        else begin
            $error("instruction request issued during reset");
            fail_cnt++;
        end

    a_reset_idle: assert property (@(posedge clk) reset |=> !fs_valid && !tlb_we)
        else begin
            $error("fs_valid or tlb_we high right after reset");
            fail_cnt++;
        end

    // zero wait states
    a_apb_ready: assert property (@(posedge clk) disable iff (reset)
        psel && penable |-> pready)
        else begin
            $error("apb access phase without pready");
            fail_cnt++;
        end

    a_cmd_reads_zero: assert property (@(posedge clk) disable iff (reset)
        psel && !pwrite && paddr == `CSR_TLBCMD |-> prdata == 32'd0)
        else begin
            $error("read of the tlb command register is not zero");
            fail_cnt++;
        end

    a_we_pulse: assert property (@(posedge clk) disable iff (reset) tlb_we |=> !tlb_we)
        else begin
            $error("tlb_we longer than one cycle");
            fail_cnt++;
        end

    a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
        inst_sram_req && inst_sram_addr_ok |=> !inst_sram_req)
        else begin
            $error("second request while one is outstanding");
            fail_cnt++;
        end

    a_hold_under_stall: assert property (@(posedge clk) disable iff (reset)
        fs_valid && !fs_allowin && !redirect |=> fs_valid && $stable(fs_out))
        else begin
            $error("fs_out changed while decode held it");
            fail_cnt++;
        end

    a_no_req_when_full: assert property (@(posedge clk) disable iff (reset)
        fs_valid && !fs_allowin |-> !inst_sram_req)
        else begin
            $error("request issued while the output slot is full");
            fail_cnt++;
        end

    a_valid_after_data: assert property (@(posedge clk) disable iff (reset)
        $rose(fs_valid) && !fs_out.ex |-> $past(inst_sram_data_ok))
        else begin
            $error("fs_valid rose without a data_ok in the cycle before");
            fail_cnt++;
        end

endmodule

bind fetch_top fetch_properties props (
    .clk               (clk),
    .reset             (reset),
    .psel              (psel),
    .penable           (penable),
    .pwrite            (pwrite),
    .paddr             (paddr),
    .pready            (pready),
    .prdata            (prdata),
    .tlb_we            (tlb_we),
    .inst_sram_req     (inst_sram_req),
    .inst_sram_addr_ok (inst_sram_addr_ok),
    .inst_sram_data_ok (inst_sram_data_ok),
    .fs_valid          (fs_valid),
    .fs_out            (fs_out),
    .fs_allowin        (fs_allowin),
    .redirect          (redirect)
);

//--- tests/fetch_tb.sv
`include "fetch_macros.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int N_DIRECT = 24;
    localparam int N_WINDOW = 16;
    localparam int N_TLB    = 16;
    // three single fault fetches at the end
    localparam int N_FETCH  = N_DIRECT + N_WINDOW + N_TLB + 3;
    localparam int WATCHDOG_TIME = 4 * (N_FETCH * 24 + 300);

    typedef struct packed {
        logic [31:0] pa;
        logic        ex;
        logic [5:0]  code;
    } ref_t;

    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic        v;
    } page_ref_t;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic        pready;
    logic [31:0] prdata;
    logic        inst_sram_req;
    logic [31:0] inst_sram_addr;
    logic        inst_sram_addr_ok;
    logic        inst_sram_data_ok;
    logic [31:0] inst_sram_rdata;
    logic        fs_valid;
    fetch_out_t  fs_out;
    logic        fs_allowin;
    logic        redirect;
    logic [31:0] redirect_pc;

    // shadow of the programmed translation state
    logic        sh_da;
    logic [1:0]  sh_plv;
    logic [2:0]  w_vseg;
    logic [2:0]  w_pseg;
    logic        w_plv0;
    logic        w_plv3;
    logic        sh_e [`TLB_NUM];
    logic [18:0] sh_vppn [`TLB_NUM];
    page_ref_t   sh_page [`TLB_NUM][2];

    logic [31:0] lfsr = 32'h1c6d;
    logic        mem_pending = 1'b0;
    logic [31:0] mem_addr;
    logic [1:0]  mem_delay;
    logic [31:0] exp_req_pc;
    logic [31:0] exp_out_pc;
    int          xfer_cnt = 0;
    int          err_cnt = 0;

    tb_clock clk_gen (.clk(clk), .reset(reset));

    fetch_top dut0 (.*);

    function automatic logic [3:0] take_bits(input int n);
        logic [3:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[2:0], lfsr[31]};
        end
        return v;
    endfunction

    function automatic logic [31:0] crmd_word(input logic da, input logic [1:0] plv);
        return {28'd0, da, 1'b0, plv};
    endfunction

    function automatic logic [31:0] dmw_word(input logic [2:0] vseg, input logic [2:0] pseg,
                                             input logic plv0, input logic plv3);
        return {vseg, 1'b0, pseg, 21'd0, plv3, 2'b00, plv0};
    endfunction

    function automatic logic [31:0] elo_word(input logic [19:0] ppn, input logic [1:0] plv,
                                             input logic v);
        // always global
        return {4'd0, ppn, 1'b0, 1'b1, 2'b00, plv, 1'b0, v};
    endfunction

    function automatic ref_t ref_xlate(input logic [31:0] pc);
        ref_t      r;
        logic      hit;
        logic      win;
        page_ref_t pg;
        r   = '{pa: pc, ex: 1'b0, code: 6'd0};
        hit = 1'b0;
        pg  = '0;
        win = (w_vseg == pc[31:29])
            && ((sh_plv == 2'd0 && w_plv0) || (sh_plv == 2'd3 && w_plv3));
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (sh_e[i] && sh_vppn[i] == pc[31:13]) begin
                hit = 1'b1;
                pg  = sh_page[i][pc[12]];
            end
        end
        if (sh_da) begin
            r.pa = pc;
        end else if (win) begin
            r.pa = {w_pseg, pc[28:0]};
        end else if (!hit) begin
            r.ex   = 1'b1;
            r.code = ECODE_TLBR;
        end else if (!pg.v) begin
            r.ex   = 1'b1;
            r.code = ECODE_PIF;
        end else if (sh_plv > pg.plv) begin
            r.ex   = 1'b1;
            r.code = ECODE_PPI;
        end else begin
            r.pa = {pg.ppn, pc[11:0]};
        end
        return r;
    endfunction

    function automatic void compare_output();
        ref_t r;
        r = ref_xlate(exp_out_pc);
        assert (fs_out.pc == exp_out_pc) else begin
            $display("FAILED fs_out.pc: got %h, expected %h", fs_out.pc, exp_out_pc);
            err_cnt++;
        end
        assert (fs_out.ex == r.ex) else begin
            $display("FAILED fs_out.ex: got %h, expected %h", fs_out.ex, r.ex);
            err_cnt++;
        end
        if (r.ex) begin
            assert (fs_out.ecode == r.code) else begin
                $display("FAILED fs_out.ecode: got %h, expected %h", fs_out.ecode, r.code);
                err_cnt++;
            end
        end else begin
            assert (fs_out.inst == ~r.pa) else begin
                $display("FAILED fs_out.inst: got %h, expected %h", fs_out.inst, ~r.pa);
                err_cnt++;
            end
        end
    endfunction

    function automatic void screen_request();
        ref_t r;
        r = ref_xlate(exp_req_pc);
        assert (!r.ex) else begin
            $display("memory request issued for pc %h, which should fault", exp_req_pc);
            err_cnt++;
        end
        assert (r.ex || inst_sram_addr == r.pa) else begin
            $display("FAILED inst_sram_addr: got %h, expected %h", inst_sram_addr, r.pa);
            err_cnt++;
        end
    endfunction

    function automatic void print_counts();
        $display("errors: %0d in checks, %0d in assertions", err_cnt, dut0.props.fail_cnt);
    endfunction

    // reference pc tracking and output checks
    always @(posedge clk) begin
        if (reset) begin
            exp_req_pc = `RESET_PC;
            exp_out_pc = `RESET_PC;
        end else begin
            if (fs_valid && fs_allowin) begin
                compare_output();
                exp_out_pc = exp_out_pc + 32'd4;
                xfer_cnt++;
            end
            if (inst_sram_req) begin
                screen_request();
            end
            if (redirect) begin
                exp_req_pc = redirect_pc;
                exp_out_pc = redirect_pc;
            end else if (inst_sram_req && inst_sram_addr_ok) begin
                exp_req_pc = exp_req_pc + 32'd4;
            end
        end
    end

    // memory model, request side
    always @(posedge clk) begin
        if (reset || inst_sram_data_ok) begin
            mem_pending = 1'b0;
        end else if (inst_sram_req && inst_sram_addr_ok) begin
            mem_pending = 1'b1;
            mem_addr    = inst_sram_addr;
            mem_delay   = 2'(take_bits(2));
        end
    end

    // memory handshakes and decode back-pressure
    always @(negedge clk) begin
        inst_sram_addr_ok = take_bits(1) != 4'd0;
        fs_allowin        = take_bits(2) != 4'd0;
        if (mem_pending && mem_delay == 2'd0) begin
            inst_sram_data_ok = 1'b1;
            inst_sram_rdata   = ~mem_addr;
        end else begin
            inst_sram_data_ok = 1'b0;
            if (mem_pending) begin
                mem_delay = mem_delay - 2'd1;
            end
        end
    end

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready) begin
            @(posedge clk);
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic tlb_fill(input logic [1:0] idx, input logic [31:0] va,
                            input page_ref_t even, input page_ref_t odd);
        apb_xfer(1'b1, `CSR_TLBIDX, {30'd0, idx});
        apb_xfer(1'b1, `CSR_TLBEHI, va);
        apb_xfer(1'b1, `CSR_TLBELO0, elo_word(even.ppn, even.plv, even.v));
        apb_xfer(1'b1, `CSR_TLBELO1, elo_word(odd.ppn, odd.plv, odd.v));
        apb_xfer(1'b1, `CSR_TLBCMD, 32'd0);
        sh_e[idx]       = 1'b1;
        sh_vppn[idx]    = va[31:13];
        sh_page[idx][0] = even;
        sh_page[idx][1] = odd;
    endtask

    task automatic wait_transfers(input int n);
        int target;
        target = xfer_cnt + n;
        while (xfer_cnt < target) begin
            @(negedge clk);
        end
    endtask

    task automatic jump_to(input logic [31:0] pc);
        redirect    = 1'b1;
        redirect_pc = pc;
        @(negedge clk);
        redirect    = 1'b0;
    endtask

    // redirect while a response is still due from memory
    task automatic redirect_outstanding(input logic [31:0] pc);
        while (!mem_pending) begin
            @(negedge clk);
        end
        jump_to(pc);
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: fetch sequence not done after %0d time units", WATCHDOG_TIME);
        print_counts();
        $display("Simulation failed");
        $finish;
    end

    initial begin
        psel              = 1'b0;
        penable           = 1'b0;
        pwrite            = 1'b0;
        paddr             = '0;
        pwdata            = '0;
        inst_sram_addr_ok = 1'b0;
        inst_sram_data_ok = 1'b0;
        inst_sram_rdata   = '0;
        fs_allowin        = 1'b1;
        redirect          = 1'b0;
        redirect_pc       = '0;
        sh_da             = 1'b1;
        sh_plv            = 2'd0;
        {w_vseg, w_pseg, w_plv0, w_plv3} = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            sh_e[i] = 1'b0;
        end
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
        end

        // direct mode
        wait_transfers(N_DIRECT / 2);
        redirect_outstanding(32'h1c00_0400);
        wait_transfers(N_DIRECT / 2);

        // window 5 onto segment 1, reconfigured under redirect
        redirect    = 1'b1;
        redirect_pc = 32'ha000_0100;
        apb_xfer(1'b1, `CSR_DMW0, dmw_word(3'd5, 3'd1, 1'b1, 1'b0));
        {w_vseg, w_pseg, w_plv0, w_plv3} = {3'd5, 3'd1, 1'b1, 1'b0};
        apb_xfer(1'b1, `CSR_CRMD, crmd_word(1'b0, 2'd0));
        sh_da    = 1'b0;
        redirect = 1'b0;
        wait_transfers(N_WINDOW);

        // tlb, crossing from the even into the odd page
        redirect    = 1'b1;
        redirect_pc = 32'h0040_0fe0;
        tlb_fill(2'd0, 32'h0040_0000, '{20'h12345, 2'd0, 1'b1}, '{20'h23456, 2'd0, 1'b1});
        tlb_fill(2'd1, 32'h0080_0000, '{20'h34567, 2'd0, 1'b0}, '{20'h45678, 2'd0, 1'b1});
        apb_xfer(1'b0, `CSR_TLBCMD, 32'd0);
        redirect = 1'b0;
        wait_transfers(N_TLB);

        // refill, then invalid page
        jump_to(32'h0060_0000);
        wait_transfers(1);
        jump_to(32'h0080_0000);
        wait_transfers(1);

        // plv3 on a plv0 page
        redirect    = 1'b1;
        redirect_pc = 32'h0080_1000;
        apb_xfer(1'b1, `CSR_CRMD, crmd_word(1'b0, 2'd3));
        sh_plv   = 2'd3;
        redirect = 1'b0;
        wait_transfers(1);

        repeat (4) @(negedge clk);
        print_counts();
        if (err_cnt == 0 && dut0.props.fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tests/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // three rising edges see reset, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule
